// File: logic/video_pkg.sv
package video_pkg;

    // Game colour depth per channel
    localparam int color_w = 4;
    // One extra bit after the bandwidth filter
    localparam int ana_w   = color_w + 1;
    localparam int out_w   = 8;

    // Pixel periods per line, blanking included
    localparam int line_len = 64;
    localparam int col_w    = 6;

    // Doubled hsync width in pxl2_cen ticks
    localparam int hs2_len  = 4;

    // Repeat the top bits to fill the low end
    function automatic logic [out_w-1:0] extend8(input logic [ana_w-1:0] a);
        return {a, a[ana_w-1 -: 3]};
    endfunction

    // Scanline dimming of the repeated line
    function automatic logic [out_w-1:0] dim(
        input logic [out_w-1:0] v,
        input logic [1:0]       mode
    );
        logic [out_w-1:0] res;
        case (mode)
            2'd0: res = v;
            // 75 %
            2'd1: res = v - (v >> 2);
            // 50 %
            2'd2: res = v - (v >> 1);
            // 25 %
            default: res = v >> 2;
        endcase
        return res;
    endfunction

endpackage

// File: logic/video_if.sv
`timescale 1ns/1ps

// Pixel stream between stages, valid when cen is high
interface video_if import video_pkg::*; #(
    parameter int W = color_w
) ();

    logic [W-1:0]     r;
    logic [W-1:0]     g;
    logic [W-1:0]     b;
    logic             hs;
    logic             vs;
    logic             lhbl;
    logic             cen;
    // First pixel after hs goes high
    logic             line_start;
    logic [col_w-1:0] x;

    modport src (
        output r, g, b, hs, vs, lhbl, cen, line_start, x
    );

    modport dst (
        input  r, g, b, hs, vs, lhbl, cen, line_start, x
    );

endinterface

// File: logic/video_in.sv
`timescale 1ns/1ps

module video_in import video_pkg::*; (
    input  logic               clk_sys,
    input  logic               rst_n,
    input  logic               pxl_cen,
    input  logic [color_w-1:0] game_r,
    input  logic [color_w-1:0] game_g,
    input  logic [color_w-1:0] game_b,
    input  logic               lhbl,
    input  logic               hs,
    input  logic               vs,
    video_if.src               pix
);

    logic hs_last;
    logic hs_rise;

    assign hs_rise = hs & ~hs_last;

    // Sync, strobe and column tracking
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            hs_last        <= 1'b0;
            pix.cen        <= 1'b0;
            pix.line_start <= 1'b0;
            pix.hs         <= 1'b0;
            pix.vs         <= 1'b0;
            pix.lhbl       <= 1'b0;
            pix.x          <= '0;
        end else begin
            pix.cen        <= pxl_cen;
            pix.line_start <= pxl_cen & hs_rise;
            if (pxl_cen) begin
                hs_last  <= hs;
                pix.hs   <= hs;
                pix.vs   <= vs;
                pix.lhbl <= lhbl;
                if (hs_rise) begin
                    pix.x <= '0;
                end else if (pix.x != col_w'(line_len - 1)) begin
                    // Saturate on over-long lines
                    pix.x <= pix.x + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            pix.r <= game_r;
            pix.g <= game_g;
            pix.b <= game_b;
        end
    end

endmodule

// File: logic/bw_filter.sv
`timescale 1ns/1ps

module bw_filter import video_pkg::*; (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic bw_en,
    video_if.dst pin,
    video_if.src pout
);

    logic [color_w-1:0] prev_r;
    logic [color_w-1:0] prev_g;
    logic [color_w-1:0] prev_b;
    logic               clr_prev;

    // Either a plain shift or the sum of two neighbours
    function automatic logic [ana_w-1:0] widen(
        input logic [color_w-1:0] cur,
        input logic [color_w-1:0] prev,
        input logic               en
    );
        logic [ana_w-1:0] res;
        if (en) begin
            res = ana_w'(cur) + ana_w'(prev);
        end else begin
            res = {cur, 1'b0};
        end
        return res;
    endfunction

    // No blending across the line edge or out of blanking
    assign clr_prev = pin.line_start | ~pin.lhbl;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            pout.cen        <= 1'b0;
            pout.line_start <= 1'b0;
            pout.hs         <= 1'b0;
            pout.vs         <= 1'b0;
            pout.lhbl       <= 1'b0;
            pout.x          <= '0;
            prev_r          <= '0;
            prev_g          <= '0;
            prev_b          <= '0;
        end else begin
            pout.cen        <= pin.cen;
            pout.line_start <= pin.cen & pin.line_start;
            if (pin.cen) begin
                pout.hs   <= pin.hs;
                pout.vs   <= pin.vs;
                pout.lhbl <= pin.lhbl;
                pout.x    <= pin.x;
                prev_r    <= pin.lhbl ? pin.r : '0;
                prev_g    <= pin.lhbl ? pin.g : '0;
                prev_b    <= pin.lhbl ? pin.b : '0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (pin.cen) begin
            pout.r <= widen(pin.r, clr_prev ? '0 : prev_r, bw_en);
            pout.g <= widen(pin.g, clr_prev ? '0 : prev_g, bw_en);
            pout.b <= widen(pin.b, clr_prev ? '0 : prev_b, bw_en);
        end
    end

    // Upstream must mark line starts on a valid pixel only
    assert property (@(posedge clk_sys) disable iff (!rst_n)
        pin.line_start |-> pin.cen);

endmodule

// File: logic/scan2x.sv
`timescale 1ns/1ps

module scan2x import video_pkg::*; (
    input  logic             clk_sys,
    input  logic             rst_n,
    input  logic             pxl2_cen,
    input  logic [1:0]       sl_mode,
    video_if.dst             pin,
    output logic [out_w-1:0] scan2x_r,
    output logic [out_w-1:0] scan2x_g,
    output logic [out_w-1:0] scan2x_b,
    output logic             scan2x_hs,
    output logic             scan2x_vs,
    output logic             scan2x_de,
    output logic             scan2x_cen
);

    // Two line halves, each entry is {lhbl, r, g, b}
    logic [3*ana_w:0]   line_buf [2*line_len];

    logic               wr_half;
    logic               wr_half_nx;
    logic               filled;
    logic               started;
    logic               active;
    logic               copy;
    logic [col_w-1:0]   rd_col;
    logic [3*ana_w:0]   rd_word;
    logic               rd_lhbl;
    logic [ana_w-1:0]   rd_r;
    logic [ana_w-1:0]   rd_g;
    logic [ana_w-1:0]   rd_b;

    // Second copy gets the scanline effect
    function automatic logic [out_w-1:0] chan(
        input logic [ana_w-1:0] c,
        input logic             dimmed,
        input logic [1:0]       mode
    );
        logic [out_w-1:0] wide;
        wide = extend8(c);
        return dimmed ? dim(wide, mode) : wide;
    endfunction

    // The line_start pixel already belongs to the new half
    assign wr_half_nx = pin.line_start ? ~wr_half : wr_half;

    always_ff @(posedge clk_sys) begin
        if (pin.cen) begin
            line_buf[{wr_half_nx, pin.x}] <= {pin.lhbl, pin.r, pin.g, pin.b};
        end
    end

    // Playback always comes from the half not being written
    assign rd_word = line_buf[{~wr_half, rd_col}];
    assign {rd_lhbl, rd_r, rd_g, rd_b} = rd_word;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            wr_half <= 1'b0;
            filled  <= 1'b0;
            started <= 1'b0;
            active  <= 1'b0;
            copy    <= 1'b0;
            rd_col  <= '0;
        end else begin
            wr_half <= wr_half_nx;
            if (pin.line_start) begin
                filled <= 1'b1;
                // First line_start only opens the first write
                if (filled) begin
                    started <= 1'b1;
                    active  <= 1'b1;
                    copy    <= 1'b0;
                    rd_col  <= '0;
                end
            end else if (pxl2_cen && active) begin
                if (rd_col == col_w'(line_len - 1)) begin
                    rd_col <= '0;
                    copy   <= 1'b1;
                    // Stop after the second pass
                    active <= ~copy;
                end else begin
                    rd_col <= rd_col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            scan2x_r   <= '0;
            scan2x_g   <= '0;
            scan2x_b   <= '0;
            scan2x_hs  <= 1'b0;
            scan2x_vs  <= 1'b0;
            scan2x_de  <= 1'b0;
            scan2x_cen <= 1'b0;
        end else begin
            scan2x_cen <= pxl2_cen & started;
            if (pin.cen) begin
                scan2x_vs <= pin.vs;
            end
            if (pxl2_cen) begin
                if (active && !pin.line_start) begin
                    scan2x_r  <= chan(rd_r, copy, sl_mode);
                    scan2x_g  <= chan(rd_g, copy, sl_mode);
                    scan2x_b  <= chan(rd_b, copy, sl_mode);
                    scan2x_hs <= int'(rd_col) < hs2_len;
                    scan2x_de <= rd_lhbl;
                end else begin
                    // Idle gap, e.g. the tick lost to a restart
                    scan2x_r  <= '0;
                    scan2x_g  <= '0;
                    scan2x_b  <= '0;
                    scan2x_hs <= 1'b0;
                    scan2x_de <= 1'b0;
                end
            end
        end
    end

    // A new line comes with hs and never cuts the first copy short
    assert property (@(posedge clk_sys) disable iff (!rst_n)
        pin.line_start |-> pin.hs && (!active || copy));

endmodule

// File: logic/video_board.sv
`timescale 1ns/1ps

module video_board import video_pkg::*; (
    input  logic               clk_sys,
    input  logic               rst_n,
    input  logic               pxl_cen,
    input  logic               pxl2_cen,
    input  logic [color_w-1:0] game_r,
    input  logic [color_w-1:0] game_g,
    input  logic [color_w-1:0] game_b,
    input  logic               lhbl,
    input  logic               hs,
    input  logic               vs,
    input  logic               bw_en,
    input  logic [1:0]         sl_mode,
    output logic [out_w-1:0]   scan2x_r,
    output logic [out_w-1:0]   scan2x_g,
    output logic [out_w-1:0]   scan2x_b,
    output logic               scan2x_hs,
    output logic               scan2x_vs,
    output logic               scan2x_de,
    output logic               scan2x_cen
);

    // Game pixels and filtered pixels
    video_if #(.W(color_w)) pix_raw ();
    video_if #(.W(ana_w))   pix_ana ();

    video_in u_video_in (
        .clk_sys    ( clk_sys    ),
        .rst_n      ( rst_n      ),
        .pxl_cen    ( pxl_cen    ),
        .game_r     ( game_r     ),
        .game_g     ( game_g     ),
        .game_b     ( game_b     ),
        .lhbl       ( lhbl       ),
        .hs         ( hs         ),
        .vs         ( vs         ),
        .pix        ( pix_raw    )
    );

    bw_filter u_bw_filter (
        .clk_sys    ( clk_sys    ),
        .rst_n      ( rst_n      ),
        .bw_en      ( bw_en      ),
        .pin        ( pix_raw    ),
        .pout       ( pix_ana    )
    );

    // Doubled output at pxl2_cen rate
    scan2x u_scan2x (
        .clk_sys    ( clk_sys    ),
        .rst_n      ( rst_n      ),
        .pxl2_cen   ( pxl2_cen   ),
        .sl_mode    ( sl_mode    ),
        .pin        ( pix_ana    ),
        .scan2x_r   ( scan2x_r   ),
        .scan2x_g   ( scan2x_g   ),
        .scan2x_b   ( scan2x_b   ),
        .scan2x_hs  ( scan2x_hs  ),
        .scan2x_vs  ( scan2x_vs  ),
        .scan2x_de  ( scan2x_de  ),
        .scan2x_cen ( scan2x_cen )
    );

endmodule

// File: bench/video_board_tb.sv
`timescale 1ns/1ps

module video_board_tb import video_pkg::*; ();

    // First active column of each input line
    localparam int act_start = 8;

    logic               clk_sys;
    logic               rst_n;
    logic               pxl_cen;
    logic               pxl2_cen;
    logic [color_w-1:0] game_r;
    logic [color_w-1:0] game_g;
    logic [color_w-1:0] game_b;
    logic               lhbl;
    logic               hs;
    logic               vs;
    logic               bw_en;
    logic [1:0]         sl_mode;
    logic [out_w-1:0]   scan2x_r;
    logic [out_w-1:0]   scan2x_g;
    logic [out_w-1:0]   scan2x_b;
    logic               scan2x_hs;
    logic               scan2x_vs;
    logic               scan2x_de;
    logic               scan2x_cen;

    // Case table
    string       case_name[$];
    int          case_bw[$];
    int          case_sl[$];
    int          case_n[$];
    int          case_ofs[$];
    logic [11:0] pix_q[$];
    logic [23:0] exp1_q[$];
    logic [23:0] exp2_q[$];

    // Captured de samples, tagged with their hs group
    logic [23:0] samp_q[$];
    int          samp_grp[$];
    int          ngroups;
    logic        hs_prev;

    video_board video_board_i (
        .clk_sys    ( clk_sys    ),
        .rst_n      ( rst_n      ),
        .pxl_cen    ( pxl_cen    ),
        .pxl2_cen   ( pxl2_cen   ),
        .game_r     ( game_r     ),
        .game_g     ( game_g     ),
        .game_b     ( game_b     ),
        .lhbl       ( lhbl       ),
        .hs         ( hs         ),
        .vs         ( vs         ),
        .bw_en      ( bw_en      ),
        .sl_mode    ( sl_mode    ),
        .scan2x_r   ( scan2x_r   ),
        .scan2x_g   ( scan2x_g   ),
        .scan2x_b   ( scan2x_b   ),
        .scan2x_hs  ( scan2x_hs  ),
        .scan2x_vs  ( scan2x_vs  ),
        .scan2x_de  ( scan2x_de  ),
        .scan2x_cen ( scan2x_cen )
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rgb(
        input string            name,
        input logic [out_w-1:0] er,
        input logic [out_w-1:0] eg,
        input logic [out_w-1:0] eb,
        input logic [out_w-1:0] ar,
        input logic [out_w-1:0] ag,
        input logic [out_w-1:0] ab
    );
        if (er !== ar || eg !== ag || eb !== ab) begin
            $display("** Error: %s expected %02h%02h%02h actual %02h%02h%02h",
                     name, er, eg, eb, ar, ag, ab);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        if (exp_n != act_n) begin
            $display("** Error: %s expected %0d actual %0d", name, exp_n, act_n);
            stop_run();
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        int          bw;
        int          sl;
        string       line;
        string       name;
        logic [11:0] p;
        logic [23:0] e1;
        logic [23:0] e2;
        fd = $fopen("bench/video_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file");
            stop_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            if ($sscanf(line, "case %s %d %d %d", name, bw, sl, n) == 4) begin
                case_name.push_back(name);
                case_bw.push_back(bw);
                case_sl.push_back(sl);
                case_n.push_back(n);
                case_ofs.push_back(pix_q.size());
            end else if ($sscanf(line, "%h %h %h", p, e1, e2) == 3) begin
                pix_q.push_back(p);
                exp1_q.push_back(e1);
                exp2_q.push_back(e2);
            end
        end
        $fclose(fd);
        if (case_name.size() == 0) begin
            $display("The cases file holds no case");
            stop_run();
        end
    endtask

    // One pixel period is 4 clocks, pxl2_cen on every second one
    task automatic drive_pixel(input logic [11:0] p, input logic h, input logic de);
        @(posedge clk_sys);
        game_r   <= p[11:8];
        game_g   <= p[7:4];
        game_b   <= p[3:0];
        hs       <= h;
        lhbl     <= de;
        pxl_cen  <= 1'b1;
        pxl2_cen <= 1'b1;
        @(posedge clk_sys);
        pxl_cen  <= 1'b0;
        pxl2_cen <= 1'b0;
        @(posedge clk_sys);
        pxl2_cen <= 1'b1;
        @(posedge clk_sys);
        pxl2_cen <= 1'b0;
    endtask

    task automatic drive_line(input int ofs, input int n);
        logic        active;
        logic [11:0] p;
        for (int col = 0; col < line_len; col++) begin
            active = col >= act_start && col < act_start + n;
            p = active ? pix_q[ofs + col - act_start] : 12'h000;
            drive_pixel(p, col < 4, active);
        end
    endtask

    // vs is not doubled, it only rides the pipeline registers
    task automatic wait_vs_level(input logic level);
        int t;
        vs <= level;
        t = 0;
        do begin
            drive_pixel(12'h000, 1'b0, 1'b0);
            @(negedge clk_sys);
            t++;
        end while (scan2x_vs !== level && t < 4);
        if (scan2x_vs !== level) begin
            $display("Timeout: scan2x_vs did not follow vs to level %0b", level);
            stop_run();
        end
    endtask

    // Output capture, one hs group per played copy
    always @(negedge clk_sys) begin
        if (rst_n) begin
            if (ngroups == 0 && (scan2x_de || scan2x_hs) && !scan2x_cen) begin
                $display("Output became active before any line was played back");
                stop_run();
            end
            if (scan2x_cen) begin
                if (scan2x_hs && !hs_prev) begin
                    ngroups = ngroups + 1;
                end
                hs_prev = scan2x_hs;
                if (scan2x_de) begin
                    if (ngroups == 0) begin
                        $display("de was high before the first output hs pulse");
                        stop_run();
                    end
                    samp_q.push_back({scan2x_r, scan2x_g, scan2x_b});
                    samp_grp.push_back(ngroups - 1);
                end
            end
        end
    end

    task automatic check_copy(input int k, input int cp);
        logic [23:0] got[$];
        logic [23:0] e;
        string       name;
        name = $sformatf("%s copy %0d", case_name[k], cp + 1);
        for (int i = 0; i < samp_q.size(); i++) begin
            if (samp_grp[i] == 2 * k + cp) begin
                got.push_back(samp_q[i]);
            end
        end
        check_count({name, " de count"}, case_n[k], got.size());
        for (int i = 0; i < case_n[k]; i++) begin
            e = cp == 0 ? exp1_q[case_ofs[k] + i] : exp2_q[case_ofs[k] + i];
            check_rgb(name, e[23:16], e[15:8], e[7:0],
                      got[i][23:16], got[i][15:8], got[i][7:0]);
        end
    endtask

    initial begin
        int nc;
        int t;
        rst_n    = 1'b0;
        pxl_cen  = 1'b0;
        pxl2_cen = 1'b0;
        game_r   = '0;
        game_g   = '0;
        game_b   = '0;
        lhbl     = 1'b0;
        hs       = 1'b0;
        vs       = 1'b0;
        bw_en    = 1'b0;
        sl_mode  = 2'd0;
        ngroups  = 0;
        hs_prev  = 1'b0;
        load_cases();
        nc = case_name.size();
        repeat (3) @(posedge clk_sys);
        rst_n <= 1'b1;

        // Line k is played during line k+1, so sl_mode trails by one case
        for (int k = 0; k < nc; k++) begin
            if (k == 1) begin
                check_count("quiet after reset", 0, ngroups);
            end
            bw_en   <= case_bw[k][0];
            sl_mode <= k > 0 ? 2'(case_sl[k - 1]) : 2'd0;
            drive_line(case_ofs[k], case_n[k]);
        end
        sl_mode <= 2'(case_sl[nc - 1]);
        drive_line(0, 0);

        t = 0;
        while (ngroups < 2 * nc && t < 200) begin
            drive_pixel(12'h000, 1'b0, 1'b0);
            t++;
        end
        if (ngroups < 2 * nc) begin
            $display("Timeout: the last line was never played back twice");
            stop_run();
        end
        // Let the second copy of the last line run out
        repeat (line_len) drive_pixel(12'h000, 1'b0, 1'b0);
        check_count("hs pulses", 2 * nc, ngroups);

        wait_vs_level(1'b1);
        wait_vs_level(1'b0);

        for (int k = 0; k < nc; k++) begin
            check_copy(k, 0);
            check_copy(k, 1);
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: bench/video_cases.txt
# case <name> <bw_en> <sl_mode> <active pixel count>
# then one line per active pixel: <game rgb, 3 hex> <first copy rgb8, 6 hex> <second copy rgb8>
case plain_sl0 0 0 4
F00 F70000 F70000
0F0 00F700 00F700
00F 0000F7 0000F7
8C4 84C642 84C642

case plain_sl1 0 1 4
123 102131 0C1925
456 425263 323E4B
9AB 94A5B5 6F7C88
EDC E7D6C6 AEA195

# Blended neighbours, previous pixel is zero before the first
case blend_sl2 1 2 5
111 080808 040404
222 181818 0C0C0C
F0F 8C108C 460846
FF0 F77B7B 7C3E3E
000 7B7B00 3E3E00

case blend_sl3 1 3 4
8F1 427B08 101E02
7A2 7BCE18 1E3306
000 395210 0E1404
FFF 7B7B7B 1E1E1E

// File: flist.f
logic/video_pkg.sv
logic/video_if.sv
logic/video_in.sv
logic/bw_filter.sv
logic/scan2x.sv
logic/video_board.sv
bench/video_board_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the video_board testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module video_board_tb \
    -o video_board_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/video_board_sim > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
